/* src.f */
+incdir+include
rtl/dispatch_pkg.sv
rtl/instr_decoder.sv
rtl/reg_status_table.sv
rtl/fu_status_table.sv
rtl/dispatch.sv
rtl/dispatch_top.sv
verif/dispatch_tb.sv

/* Makefile */
# Verilator build and run of the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= dispatch_tb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f src.f
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/dispatch_tb.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch_tb;

    // rough scripted length in cycles, hazard waits included
    localparam int SCRIPT_CYCLES = 200;
    localparam int RUN_LIMIT     = 10 * SCRIPT_CYCLES;

    logic                 CLK = 1'b0;
    logic                 nRST;
    logic                 fetch_valid;
    dispatch_pkg::instr_u fetch_instr;
    logic                 branch_miss;
    logic                 branch_resolved;
    logic                 wb_s_en;
    logic [`S_IDX_W-1:0]  wb_s_rd;
    logic                 wb_m_en;
    logic [`M_IDX_W-1:0]  wb_m_rd;
    logic [`NUM_FU-1:0]   fu_done;
    logic                 freeze;
    logic                 issue_valid;
    dispatch_pkg::fu_id_t issue_fu;
    logic [`S_IDX_W-1:0]  issue_rd;
    logic [`S_IDX_W-1:0]  issue_rs1;
    logic [`S_IDX_W-1:0]  issue_rs2;
    logic [`WORD_W-1:0]   issue_imm;
    logic [`TAG_W-1:0]    issue_t1;
    logic [`TAG_W-1:0]    issue_t2;
    logic                 issue_spec;
    logic                 halt;

    // reference model state
    logic [`S_REGS-1:0] ref_sbusy;
    logic [`S_REGS-1:0] ref_sspec;
    logic [1:0]         ref_stag [`S_REGS];
    logic [`M_REGS-1:0] ref_mbusy;
    logic [1:0]         ref_mtag [`M_REGS];
    logic [`NUM_FU-1:0] ref_fu_busy;
    logic               ref_spec;
    logic               ref_halt;
    logic               ref_valid;
    logic [2:0]         ref_fu;
    logic [4:0]         ref_rd;
    logic [4:0]         ref_rs1;
    logic [4:0]         ref_rs2;
    logic [31:0]        ref_imm;
    logic [1:0]         ref_t1;
    logic [1:0]         ref_t2;
    logic               ref_ispec;
    logic [2:0]         d_unit;
    logic [1:0]         d_stag;
    logic [1:0]         d_mtag;
    logic               d_gemm;
    logic               exp_freeze;
    logic               ref_accept;

    logic [31:0] lcg_state = 32'hb45269bf;
    string       test_name = "reset";
    int          err_count = 0;
    int          issues    = 0;
    int          cycles    = 0;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic [11:0] rimm;

    dispatch_top dut_i (.*);

    always #50 CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[31:27];
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] op, input logic [4:0] rd, rs1, rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, op};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [4:0] rd, rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, op};
    endfunction

    function automatic logic [31:0] m_word(input logic [6:0] op, input logic [3:0] md, ms1, ms2);
        return {md, ms1, ms2, 4'd0, 9'd0, op};
    endfunction

    // unit and destination tags per opcode, zero tag means no destination
    function automatic void classify(input logic [6:0] op, output logic [2:0] unit,
                                     output logic [1:0] s_tag, output logic [1:0] m_tag);
        unit  = 3'd0;
        s_tag = 2'd0;
        m_tag = 2'd0;
        case (op)
            `OP_ALU, `OP_ALUI: s_tag = 2'd1;
            `OP_LOAD: begin
                unit  = 3'd1;
                s_tag = 2'd2;
            end
            `OP_STORE:  unit = 3'd1;
            `OP_BRANCH: unit = 3'd2;
            `OP_JAL: begin
                unit  = 3'd2;
                s_tag = 2'd3;
            end
            `OP_MLOAD: begin
                unit  = 3'd3;
                m_tag = 2'd2;
            end
            `OP_GEMM: begin
                unit  = 3'd4;
                m_tag = 2'd1;
            end
            default: unit = 3'd0;
        endcase
    endfunction

    // a unit stays occupied while its op waits in the issue register
    always_comb begin
        classify(fetch_instr.r.opcode, d_unit, d_stag, d_mtag);
        d_gemm     = (d_unit == 3'd4);
        exp_freeze = fetch_valid && ((ref_fu_busy[d_unit] && !fu_done[d_unit])
                     || (ref_valid && (ref_fu == d_unit))
                     || ((d_stag != 2'd0) && ref_sbusy[fetch_instr.r.rd])
                     || ((d_mtag != 2'd0) && ref_mbusy[fetch_instr.m.md]));
        ref_accept = fetch_valid && !exp_freeze && !branch_miss;
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ref_sbusy   <= '0;
            ref_sspec   <= '0;
            ref_mbusy   <= '0;
            ref_fu_busy <= '0;
            ref_spec    <= 1'b0;
            ref_halt    <= 1'b0;
            ref_valid   <= 1'b0;
            for (int i = 0; i < `S_REGS; i++) ref_stag[i] <= 2'd0;
            for (int i = 0; i < `M_REGS; i++) ref_mtag[i] <= 2'd0;
        end else begin
            for (int i = 0; i < `S_REGS; i++) begin
                if (ref_accept && (d_stag != 2'd0) && (fetch_instr.r.rd == 5'(i))) begin
                    ref_sbusy[i] <= 1'b1;
                    ref_stag[i]  <= d_stag;
                    ref_sspec[i] <= ref_spec;
                end else if ((wb_s_en && (wb_s_rd == 5'(i))) || (branch_miss && ref_sspec[i])) begin
                    ref_sbusy[i] <= 1'b0;
                    ref_stag[i]  <= 2'd0;
                    ref_sspec[i] <= 1'b0;
                end else if (branch_resolved) begin
                    ref_sspec[i] <= 1'b0;
                end
            end
            for (int i = 0; i < `M_REGS; i++) begin
                if (ref_accept && (d_mtag != 2'd0) && (fetch_instr.m.md == 4'(i))) begin
                    ref_mbusy[i] <= 1'b1;
                    ref_mtag[i]  <= d_mtag;
                end else if (wb_m_en && (wb_m_rd == 4'(i))) begin
                    ref_mbusy[i] <= 1'b0;
                    ref_mtag[i]  <= 2'd0;
                end
            end
            for (int u = 0; u < `NUM_FU; u++) begin
                if (ref_valid && (ref_fu == 3'(u))) ref_fu_busy[u] <= 1'b1;
                else if (fu_done[u]) ref_fu_busy[u] <= 1'b0;
            end
            if (ref_accept && (fetch_instr.r.opcode == `OP_BRANCH)) ref_spec <= 1'b1;
            else if (branch_resolved || branch_miss) ref_spec <= 1'b0;
            if (ref_accept && (fetch_instr.r.opcode == `OP_HALT)) ref_halt <= 1'b1;
            ref_valid <= ref_accept;
            if (ref_accept) begin
                ref_fu    <= d_unit;
                ref_rd    <= d_gemm ? {1'b0, fetch_instr.m.md}  : fetch_instr.r.rd;
                ref_rs1   <= d_gemm ? {1'b0, fetch_instr.m.ms1} : fetch_instr.r.rs1;
                ref_rs2   <= d_gemm ? {1'b0, fetch_instr.m.ms2} : fetch_instr.r.rs2;
                ref_imm   <= {{20{fetch_instr.i.imm[11]}}, fetch_instr.i.imm};
                ref_t1    <= d_gemm ? ref_mtag[fetch_instr.m.ms1] : ref_stag[fetch_instr.r.rs1];
                ref_t2    <= d_gemm ? ref_mtag[fetch_instr.m.ms2] : ref_stag[fetch_instr.r.rs2];
                ref_ispec <= ref_spec;
            end
        end
    end

    task automatic log_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        err_count++;
        $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    a_freeze: assert property (@(posedge CLK) disable iff (!nRST) freeze == exp_freeze)
        else log_mismatch("freeze", 64'($sampled(exp_freeze)), 64'($sampled(freeze)));
    a_valid: assert property (@(posedge CLK) disable iff (!nRST) issue_valid == ref_valid)
        else log_mismatch("issue_valid", 64'($sampled(ref_valid)), 64'($sampled(issue_valid)));
    a_halt: assert property (@(posedge CLK) disable iff (!nRST) halt == ref_halt)
        else log_mismatch("halt", 64'($sampled(ref_halt)), 64'($sampled(halt)));
    a_payload: assert property (@(posedge CLK) disable iff (!nRST) issue_valid |->
        {issue_fu, issue_rd, issue_rs1, issue_rs2, issue_imm}
            == {ref_fu, ref_rd, ref_rs1, ref_rs2, ref_imm})
        else log_mismatch("fu/rd/rs1/rs2/imm",
            64'($sampled({ref_fu, ref_rd, ref_rs1, ref_rs2, ref_imm})),
            64'($sampled({issue_fu, issue_rd, issue_rs1, issue_rs2, issue_imm})));
    a_tags: assert property (@(posedge CLK) disable iff (!nRST) issue_valid |->
        {issue_t1, issue_t2, issue_spec} == {ref_t1, ref_t2, ref_ispec})
        else log_mismatch("t1/t2/spec", 64'($sampled({ref_t1, ref_t2, ref_ispec})),
            64'($sampled({issue_t1, issue_t2, issue_spec})));

    task automatic finish_run(input logic timed_out);
        $display("issues: %0d  errors: %0d  timeouts: %0d", issues, err_count, timed_out);
        if ((err_count == 0) && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    always @(negedge CLK) begin
        cycles++;
        if (issue_valid) issues++;
        if (cycles >= RUN_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            finish_run(1'b1);
        end
    end

    // pulse inputs last one cycle
    task automatic step();
        @(posedge CLK);
        fu_done         <= '0;
        wb_s_en         <= 1'b0;
        wb_m_en         <= 1'b0;
        branch_miss     <= 1'b0;
        branch_resolved <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // hold the word at fetch until the stage takes it
    task automatic send(input logic [31:0] word);
        fetch_valid <= 1'b1;
        fetch_instr <= word;
        @(negedge CLK);
        while (freeze || branch_miss) begin
            step();
            @(negedge CLK);
        end
        step();
        fetch_valid <= 1'b0;
    endtask

    task automatic present(input logic [31:0] word);
        fetch_valid <= 1'b1;
        fetch_instr <= word;
    endtask

    task automatic retire(input int u);
        step();
        fu_done[u] <= 1'b1;
        step();
    endtask

    task automatic wb_scalar(input logic [4:0] r);
        wb_s_en <= 1'b1;
        wb_s_rd <= r;
        step();
    endtask

    task automatic wb_matrix(input logic [3:0] r);
        wb_m_en <= 1'b1;
        wb_m_rd <= r;
        step();
    endtask

    initial begin
        nRST            = 1'b0;
        fetch_valid     = 1'b0;
        fetch_instr     = '0;
        branch_miss     = 1'b0;
        branch_resolved = 1'b0;
        wb_s_en         = 1'b0;
        wb_s_rd         = '0;
        wb_m_en         = 1'b0;
        wb_m_rd         = '0;
        fu_done         = '0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        idle(4);

        test_name = "decode";
        for (int k = 0; k < 4; k++) begin
            ra   = pick_reg();
            rb   = pick_reg();
            rc   = pick_reg();
            rimm = 12'(lcg_next());
            send(r_word(`OP_ALU, ra, rb, rc));
            retire(0);
            wb_scalar(ra);
            send(i_word(`OP_LOAD, rb, rc, rimm));
            retire(1);
            wb_scalar(rb);
            send(m_word(`OP_GEMM, ra[3:0], rb[3:0], rc[3:0]));
            retire(4);
            wb_matrix(ra[3:0]);
        end

        test_name = "structural";
        send(r_word(`OP_ALU, 5'd1, 5'd2, 5'd3));
        present(r_word(`OP_ALU, 5'd4, 5'd2, 5'd3));
        idle(3);
        fu_done[0] <= 1'b1;
        send(r_word(`OP_ALU, 5'd4, 5'd2, 5'd3));
        retire(0);
        wb_scalar(5'd1);
        wb_scalar(5'd4);

        test_name = "waw_tags";
        send(i_word(`OP_LOAD, 5'd5, 5'd0, 12'hf80));
        retire(1);
        send(r_word(`OP_ALU, 5'd6, 5'd5, 5'd0));
        retire(0);
        send(r_word(`OP_ALU, 5'd7, 5'd6, 5'd5));
        retire(0);
        send(i_word(`OP_JAL, 5'd13, 5'd0, 12'h010));
        retire(2);
        send(r_word(`OP_STORE, 5'd0, 5'd13, 5'd7));
        retire(1);
        present(r_word(`OP_ALU, 5'd5, 5'd0, 5'd0));
        idle(3);
        wb_scalar(5'd5);
        send(r_word(`OP_ALU, 5'd5, 5'd0, 5'd0));
        retire(0);
        for (int r = 5; r <= 7; r++) wb_scalar(5'(r));
        wb_scalar(5'd13);
        send(m_word(`OP_MLOAD, 4'd3, 4'd0, 4'd0));
        retire(3);
        send(m_word(`OP_GEMM, 4'd4, 4'd3, 4'd3));
        retire(4);
        send(m_word(`OP_GEMM, 4'd5, 4'd4, 4'd3));
        retire(4);
        present(m_word(`OP_GEMM, 4'd4, 4'd5, 4'd5));
        idle(2);
        wb_m_en <= 1'b1;
        wb_m_rd <= 4'd4;
        send(m_word(`OP_GEMM, 4'd4, 4'd5, 4'd5));
        retire(4);
        for (int r = 3; r <= 5; r++) wb_matrix(4'(r));

        test_name = "speculation";
        send(r_word(`OP_ALU, 5'd8, 5'd0, 5'd0));
        retire(0);
        send(r_word(`OP_BRANCH, 5'd0, 5'd1, 5'd2));
        retire(2);
        send(r_word(`OP_ALU, 5'd9, 5'd8, 5'd0));
        retire(0);
        send(i_word(`OP_LOAD, 5'd10, 5'd9, 12'h004));
        retire(1);
        // mispredict while a store waits at fetch
        branch_miss <= 1'b1;
        send(r_word(`OP_STORE, 5'd0, 5'd9, 5'd8));
        retire(1);
        // r9 and r10 come back free from the flush
        send(r_word(`OP_ALU, 5'd9, 5'd0, 5'd0));
        retire(0);
        send(i_word(`OP_LOAD, 5'd10, 5'd0, 12'h008));
        retire(1);
        send(r_word(`OP_BRANCH, 5'd0, 5'd3, 5'd4));
        retire(2);
        send(r_word(`OP_ALU, 5'd12, 5'd0, 5'd0));
        retire(0);
        // r12 loses only its speculative mark
        branch_resolved <= 1'b1;
        step();
        present(r_word(`OP_ALU, 5'd12, 5'd0, 5'd0));
        idle(2);
        wb_s_en <= 1'b1;
        wb_s_rd <= 5'd12;
        send(r_word(`OP_ALU, 5'd12, 5'd0, 5'd0));
        retire(0);
        for (int r = 8; r <= 12; r++) wb_scalar(5'(r));

        test_name = "halt";
        send(r_word(`OP_HALT, 5'd0, 5'd0, 5'd0));
        idle(5);
        finish_run(1'b0);
    end

endmodule

/* rtl/dispatch_top.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 fetch_valid,
    input  dispatch_pkg::instr_u fetch_instr,
    input  logic                 branch_miss,
    input  logic                 branch_resolved,
    input  logic                 wb_s_en,
    input  logic [`S_IDX_W-1:0]  wb_s_rd,
    input  logic                 wb_m_en,
    input  logic [`M_IDX_W-1:0]  wb_m_rd,
    input  logic [`NUM_FU-1:0]   fu_done,
    output logic                 freeze,
    output logic                 issue_valid,
    output dispatch_pkg::fu_id_t issue_fu,
    output logic [`S_IDX_W-1:0]  issue_rd,
    output logic [`S_IDX_W-1:0]  issue_rs1,
    output logic [`S_IDX_W-1:0]  issue_rs2,
    output logic [`WORD_W-1:0]   issue_imm,
    output logic [`TAG_W-1:0]    issue_t1,
    output logic [`TAG_W-1:0]    issue_t2,
    output logic                 issue_spec,
    output logic                 halt
);

    logic [`NUM_FU-1:0] fu_busy;

    dispatch dispatch_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .fetch_valid     (fetch_valid),
        .fetch_instr     (fetch_instr),
        .branch_miss     (branch_miss),
        .branch_resolved (branch_resolved),
        .wb_s_en         (wb_s_en),
        .wb_s_rd         (wb_s_rd),
        .wb_m_en         (wb_m_en),
        .wb_m_rd         (wb_m_rd),
        .fu_done         (fu_done),
        .fu_busy         (fu_busy),
        .freeze          (freeze),
        .issue_valid     (issue_valid),
        .issue_fu        (issue_fu),
        .issue_rd        (issue_rd),
        .issue_rs1       (issue_rs1),
        .issue_rs2       (issue_rs2),
        .issue_imm       (issue_imm),
        .issue_t1        (issue_t1),
        .issue_t2        (issue_t2),
        .issue_spec      (issue_spec),
        .halt            (halt)
    );

    // unit occupancy, fed back to hazard detection
    fu_status_table fust_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_fu    (issue_fu),
        .fu_done     (fu_done),
        .busy        (fu_busy)
    );

endmodule

/* rtl/dispatch.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module dispatch (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  fetch_valid,
    input  dispatch_pkg::instr_u  fetch_instr,
    input  logic                  branch_miss,
    input  logic                  branch_resolved,
    input  logic                  wb_s_en,
    input  logic [`S_IDX_W-1:0]   wb_s_rd,
    input  logic                  wb_m_en,
    input  logic [`M_IDX_W-1:0]   wb_m_rd,
    input  logic [`NUM_FU-1:0]    fu_done,
    input  logic [`NUM_FU-1:0]    fu_busy,
    output logic                  freeze,
    output logic                  issue_valid,
    output dispatch_pkg::fu_id_t  issue_fu,
    output logic [`S_IDX_W-1:0]   issue_rd,
    output logic [`S_IDX_W-1:0]   issue_rs1,
    output logic [`S_IDX_W-1:0]   issue_rs2,
    output logic [`WORD_W-1:0]    issue_imm,
    output logic [`TAG_W-1:0]     issue_t1,
    output logic [`TAG_W-1:0]     issue_t2,
    output logic                  issue_spec,
    output logic                  halt
);

    dispatch_pkg::fu_id_t       dec_fu;
    dispatch_pkg::branch_kind_t dec_branch;
    logic                       dec_s_write;
    logic                       dec_m_write;
    logic [`WORD_W-1:0]         dec_imm;
    logic                       dec_halt;
    logic                       is_gemm;
    logic                       struct_haz;
    logic                       waw_haz;
    logic                       accept;
    logic                       spec_q;
    logic                       s_dest_busy;
    logic                       m_dest_busy;
    logic [`TAG_W-1:0]          s_di_tag;
    logic [`TAG_W-1:0]          m_di_tag;
    logic [`TAG_W-1:0]          s_tag_a;
    logic [`TAG_W-1:0]          s_tag_b;
    logic [`TAG_W-1:0]          m_tag_a;
    logic [`TAG_W-1:0]          m_tag_b;

    instr_decoder dec_i (
        .instr       (fetch_instr),
        .fu          (dec_fu),
        .s_write     (dec_s_write),
        .m_write     (dec_m_write),
        .branch_kind (dec_branch),
        .imm         (dec_imm),
        .is_halt     (dec_halt)
    );

    reg_status_table #(.REGS(`S_REGS), .IDX_W(`S_IDX_W)) s_rst_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .di_write  (accept && dec_s_write),
        .di_sel    (fetch_instr.r.rd),
        .di_tag    (s_di_tag),
        .di_spec   (spec_q),
        .wb_write  (wb_s_en),
        .wb_sel    (wb_s_rd),
        .flush     (branch_miss),
        .resolved  (branch_resolved),
        .rd_sel_a  (fetch_instr.r.rs1),
        .rd_sel_b  (fetch_instr.r.rs2),
        .dest_sel  (fetch_instr.r.rd),
        .dest_busy (s_dest_busy),
        .tag_a     (s_tag_a),
        .tag_b     (s_tag_b)
    );

    // matrix claims are never speculative
    reg_status_table #(.REGS(`M_REGS), .IDX_W(`M_IDX_W)) m_rst_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .di_write  (accept && dec_m_write),
        .di_sel    (fetch_instr.m.md),
        .di_tag    (m_di_tag),
        .di_spec   (1'b0),
        .wb_write  (wb_m_en),
        .wb_sel    (wb_m_rd),
        .flush     (1'b0),
        .resolved  (1'b0),
        .rd_sel_a  (fetch_instr.m.ms1),
        .rd_sel_b  (fetch_instr.m.ms2),
        .dest_sel  (fetch_instr.m.md),
        .dest_busy (m_dest_busy),
        .tag_a     (m_tag_a),
        .tag_b     (m_tag_b)
    );

    assign is_gemm = (dec_fu == dispatch_pkg::FU_GEMM);

    // producer tag for the claimed destination
    always_comb begin
        case (dec_fu)
            dispatch_pkg::FU_LDST:   s_di_tag = dispatch_pkg::TAG_LOAD;
            dispatch_pkg::FU_BRANCH: s_di_tag = dispatch_pkg::TAG_JUMP;
            dispatch_pkg::FU_ALU:    s_di_tag = dispatch_pkg::TAG_ALU;
            default:                 s_di_tag = dispatch_pkg::TAG_NONE;
        endcase
    end
    assign m_di_tag = is_gemm ? `MTAG_GEMM : `MTAG_MLOAD;

    // the op sitting in the issue register has not reached the unit table yet
    assign struct_haz = (fu_busy[dec_fu] && !fu_done[dec_fu])
                      || (issue_valid && (issue_fu == dec_fu));
    assign waw_haz    = (dec_s_write && s_dest_busy) || (dec_m_write && m_dest_busy);
    assign freeze     = fetch_valid && (struct_haz || waw_haz);
    assign accept     = fetch_valid && !freeze && !branch_miss;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec_q <= 1'b0;
            halt   <= 1'b0;
        end else begin
            if (accept && (dec_branch == dispatch_pkg::BR_COND)) begin
                spec_q <= 1'b1;
            end else if (branch_resolved || branch_miss) begin
                spec_q <= 1'b0;
            end
            // sticky until reset
            if (accept && dec_halt) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    // payload only loads on acceptance
    always_ff @(posedge CLK) begin
        if (accept) begin
            issue_fu   <= dec_fu;
            issue_rd   <= is_gemm ? `S_IDX_W'(fetch_instr.m.md)  : fetch_instr.r.rd;
            issue_rs1  <= is_gemm ? `S_IDX_W'(fetch_instr.m.ms1) : fetch_instr.r.rs1;
            issue_rs2  <= is_gemm ? `S_IDX_W'(fetch_instr.m.ms2) : fetch_instr.r.rs2;
            issue_imm  <= dec_imm;
            issue_t1   <= is_gemm ? m_tag_a : s_tag_a;
            issue_t2   <= is_gemm ? m_tag_b : s_tag_b;
            issue_spec <= spec_q;
        end
    end

    // a mispredict squashes whatever was at fetch
    a_miss_squash: assert property (@(posedge CLK) disable iff (!nRST)
        branch_miss |=> !issue_valid);

endmodule

/* rtl/fu_status_table.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module fu_status_table (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 issue_valid,
    input  dispatch_pkg::fu_id_t issue_fu,
    input  logic [`NUM_FU-1:0]   fu_done,
    output logic [`NUM_FU-1:0]   busy
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < `NUM_FU; i++) begin
                // a fresh issue outranks completion of the previous op
                if (issue_valid && (issue_fu == dispatch_pkg::fu_id_t'(i))) begin
                    busy[i] <= 1'b1;
                end else if (fu_done[i]) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    // dispatch must never send work to an occupied unit
    a_no_issue_to_busy: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> !(busy[issue_fu] && !fu_done[issue_fu]));

endmodule

/* rtl/reg_status_table.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module reg_status_table #(
    parameter int REGS  = 32,
    parameter int IDX_W = 5
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              di_write,
    input  logic [IDX_W-1:0]  di_sel,
    input  logic [`TAG_W-1:0] di_tag,
    input  logic              di_spec,
    input  logic              wb_write,
    input  logic [IDX_W-1:0]  wb_sel,
    input  logic              flush,
    input  logic              resolved,
    input  logic [IDX_W-1:0]  rd_sel_a,
    input  logic [IDX_W-1:0]  rd_sel_b,
    input  logic [IDX_W-1:0]  dest_sel,
    output logic              dest_busy,
    output logic [`TAG_W-1:0] tag_a,
    output logic [`TAG_W-1:0] tag_b
);

    logic [REGS-1:0]   busy;
    logic [REGS-1:0]   spec;
    logic [`TAG_W-1:0] tag [REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            spec <= '0;
            for (int i = 0; i < REGS; i++) begin
                tag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REGS; i++) begin
                // new claim beats a writeback to the same entry
                if (di_write && (di_sel == IDX_W'(i))) begin
                    busy[i] <= 1'b1;
                    tag[i]  <= di_tag;
                    spec[i] <= di_spec;
                end else if ((wb_write && (wb_sel == IDX_W'(i))) || (flush && spec[i])) begin
                    busy[i] <= 1'b0;
                    tag[i]  <= '0;
                    spec[i] <= 1'b0;
                end else if (resolved) begin
                    spec[i] <= 1'b0;
                end
            end
        end
    end

    // lookups are combinational
    assign dest_busy = busy[dest_sel];
    assign tag_a     = tag[rd_sel_a];
    assign tag_b     = tag[rd_sel_b];

    // dispatch holds off any claim on a pending register
    a_no_double_claim: assert property (@(posedge CLK) disable iff (!nRST)
        di_write |-> !busy[di_sel]);

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`include "dispatch_defs.svh"

module instr_decoder (
    input  dispatch_pkg::instr_u       instr,
    output dispatch_pkg::fu_id_t       fu,
    output logic                       s_write,
    output logic                       m_write,
    output dispatch_pkg::branch_kind_t branch_kind,
    output logic [`WORD_W-1:0]         imm,
    output logic                       is_halt
);

    // only one immediate format is supported
    assign imm = {{(`WORD_W-12){instr.i.imm[11]}}, instr.i.imm};

    always_comb begin
        // unknown opcodes fall through as an ALU no-op
        fu          = dispatch_pkg::FU_ALU;
        s_write     = 1'b0;
        m_write     = 1'b0;
        branch_kind = dispatch_pkg::BR_NONE;
        is_halt     = 1'b0;
        case (instr.r.opcode)
            `OP_ALU, `OP_ALUI: begin
                s_write = 1'b1;
            end
            `OP_LOAD: begin
                fu      = dispatch_pkg::FU_LDST;
                s_write = 1'b1;
            end
            `OP_STORE: begin
                fu = dispatch_pkg::FU_LDST;
            end
            `OP_BRANCH: begin
                fu          = dispatch_pkg::FU_BRANCH;
                branch_kind = dispatch_pkg::BR_COND;
            end
            `OP_JAL: begin
                // link register is claimed with the jump tag
                fu          = dispatch_pkg::FU_BRANCH;
                s_write     = 1'b1;
                branch_kind = dispatch_pkg::BR_JAL;
            end
            `OP_MLOAD: begin
                fu      = dispatch_pkg::FU_MLDST;
                m_write = 1'b1;
            end
            `OP_GEMM: begin
                fu      = dispatch_pkg::FU_GEMM;
                m_write = 1'b1;
            end
            `OP_HALT: begin
                is_halt = 1'b1;
            end
            default: begin
                fu = dispatch_pkg::FU_ALU;
            end
        endcase
    end

endmodule

/* rtl/dispatch_pkg.sv */
`include "dispatch_defs.svh"

package dispatch_pkg;

    // unit number, also the bit index into busy and done vectors
    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_LDST   = 3'd1,
        FU_BRANCH = 3'd2,
        FU_MLDST  = 3'd3,
        FU_GEMM   = 3'd4
    } fu_id_t;

    // scalar producer tags
    typedef enum logic [`TAG_W-1:0] {
        TAG_NONE = 2'd0,
        TAG_ALU  = 2'd1,
        TAG_LOAD = 2'd2,
        TAG_JUMP = 2'd3
    } tag_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JAL  = 2'd2
    } branch_kind_t;

    // register-register scalar format
    typedef struct packed {
        logic [6:0]          funct7;
        logic [`S_IDX_W-1:0] rs2;
        logic [`S_IDX_W-1:0] rs1;
        logic [2:0]          funct3;
        logic [`S_IDX_W-1:0] rd;
        logic [6:0]          opcode;
    } instr_r_t;

    // immediate scalar format
    typedef struct packed {
        logic [11:0]         imm;
        logic [`S_IDX_W-1:0] rs1;
        logic [2:0]          funct3;
        logic [`S_IDX_W-1:0] rd;
        logic [6:0]          opcode;
    } instr_i_t;

    // matrix format, bits 15..7 unused
    typedef struct packed {
        logic [`M_IDX_W-1:0] md;
        logic [`M_IDX_W-1:0] ms1;
        logic [`M_IDX_W-1:0] ms2;
        logic [`M_IDX_W-1:0] ms3;
        logic [8:0]          rsvd;
        logic [6:0]          opcode;
    } instr_m_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_m_t m;
    } instr_u;

endpackage

/* include/dispatch_defs.svh */
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// datapath widths
`define WORD_W      32
`define S_REGS      32
`define S_IDX_W     5
`define M_REGS      16
`define M_IDX_W     4
`define NUM_FU      5
`define TAG_W       2

// opcodes, bits 6..0 of the instruction word
`define OP_ALU      7'b0110011
`define OP_ALUI     7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_MLOAD    7'b0001011
`define OP_GEMM     7'b0101011
`define OP_HALT     7'b1111111

// matrix table producer codes
`define MTAG_GEMM   2'd1
`define MTAG_MLOAD  2'd2

`endif
